//--- logic/isa_pkg.sv
package isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // geometry of the word, the program store and the accumulator
    //////////////////////////////////////////////////////////////////////

    localparam int inst_width    = 16;
    localparam int im_addr_width = 4;
    localparam int im_depth      = 16;
    // one bit wider than the address so a full program of 16 fits
    localparam int cnt_width     = 5;
    localparam int data_width    = 16;

    // field widths inside one instruction word
    localparam int op_width    = 4;
    localparam int imm_width   = 12;
    localparam int shamt_width = 4;

    // opcodes, anything else is a no-op
    localparam logic [op_width-1:0] op_ldi = 4'd0;
    localparam logic [op_width-1:0] op_add = 4'd1;
    localparam logic [op_width-1:0] op_sub = 4'd2;
    localparam logic [op_width-1:0] op_xor = 4'd3;
    localparam logic [op_width-1:0] op_shl = 4'd4;
    localparam logic [op_width-1:0] op_shr = 4'd5;

    //////////////////////////////////////////////////////////////////////
    // configuration block
    //////////////////////////////////////////////////////////////////////

    localparam int cfg_width = 4;
    localparam logic cfg_addr_gap    = 1'b0;
    localparam logic cfg_addr_passes = 1'b1;
    localparam logic [cfg_width-1:0] gap_reset    = 4'd8;
    localparam logic [cfg_width-1:0] passes_reset = 4'd1;

    // immediate form
    typedef struct packed {
        logic [op_width-1:0]  opcode;
        logic [imm_width-1:0] imm;
    } inst_imm_t;

    // shift form, low byte ignored
    typedef struct packed {
        logic [op_width-1:0]                        opcode;
        logic [shamt_width-1:0]                     shamt;
        logic [inst_width-op_width-shamt_width-1:0] unused;
    } inst_shift_t;

    // same 16 bits, two decodings
    typedef union packed {
        inst_imm_t   imm_view;
        inst_shift_t shift_view;
    } inst_u;

endpackage

//--- logic/imem_if.sv
`timescale 1ns/1ps

interface imem_if import isa_pkg::*; ();

    // write port, loading phase only
    logic                     wr_en;
    logic [im_addr_width-1:0] wr_addr;
    logic [inst_width-1:0]    wr_data;

    // read port, replay phase only
    logic                     rd_en;
    logic [im_addr_width-1:0] rd_addr;
    logic [inst_width-1:0]    rd_data;
    logic                     rd_valid;

    // controller side
    // rd_valid comes back so done can line up with the data
    modport ctrl (
        output wr_en, wr_addr, wr_data, rd_en, rd_addr,
        input  rd_valid
    );

    // memory side
    modport mem (
        input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
        output rd_data, rd_valid
    );

endinterface

//--- logic/cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs import isa_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_we,
    input  logic                 cfg_addr,
    input  logic [cfg_width-1:0] cfg_wdata,
    output logic [cfg_width-1:0] cfg_rdata,
    output logic [cfg_width-1:0] gap_len,
    output logic [cfg_width-1:0] passes
);

    //////////////////////////////////////////////////////////////////////
    // steering registers
    //////////////////////////////////////////////////////////////////////

    // idle cycles tolerated inside a load, run starts after gap_len+1
    logic [cfg_width-1:0] gap_q;
    // how many times the stored program replays
    logic [cfg_width-1:0] passes_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            gap_q    <= gap_reset;
            passes_q <= passes_reset;
        end else if (cfg_we) begin
            // one register per address
            case (cfg_addr)
                cfg_addr_gap:    gap_q    <= cfg_wdata;
                cfg_addr_passes: passes_q <= cfg_wdata;
            endcase
        end
    end

    // fetch_ctrl latches passes at run start
    // so a write here mid-run only hits the next run
    assign gap_len = gap_q;
    assign passes  = passes_q;

    //////////////////////////////////////////////////////////////////////
    // readback
    //////////////////////////////////////////////////////////////////////

    // combinational, follows cfg_addr directly
    always_comb begin
        case (cfg_addr)
            cfg_addr_gap:    cfg_rdata = gap_q;
            cfg_addr_passes: cfg_rdata = passes_q;
            default:         cfg_rdata = '0;
        endcase
    end

endmodule

//--- logic/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl import isa_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid,
    input  logic [inst_width-1:0] inst_in,
    input  logic [cfg_width-1:0]  gap_len,
    input  logic [cfg_width-1:0]  passes,
    imem_if.ctrl                  mem,
    output logic                  run_start,
    output logic                  busy,
    output logic                  done
);

    // words loaded so far, saturates at im_depth
    logic [cnt_width-1:0]     len_cnt;
    // consecutive idle cycles since the last beat
    logic [cfg_width-1:0]     gap_cnt;
    // replay program counter and passes still to issue
    logic [im_addr_width-1:0] pc;
    logic [cfg_width-1:0]     pass_left;
    logic                     issuing;
    // copy of the last-read flag, one stage behind the read
    logic                     last_d1;

    logic beat;
    logic room;
    logic load_end;
    logic wrap;
    logic last_read;
    logic done_next;

    //////////////////////////////////////////////////////////////////////
    // phase decode
    //////////////////////////////////////////////////////////////////////

    // beats while busy are dropped
    assign beat = valid & ~busy;
    assign room = (len_cnt != cnt_width'(im_depth));

    // counter instead of a fixed valid delay line
    // needs at least one word before the gap counts
    assign load_end = ~busy & ~valid & (len_cnt != '0) & (gap_cnt >= gap_len);

    // pc at the final word of the program
    assign wrap      = ({1'b0, pc} == (len_cnt - cnt_width'(1)));
    assign last_read = issuing & wrap & (pass_left == cfg_width'(1));

    // normal end lines up with the last rd_valid
    // zero passes ends the cycle after run_start
    assign done_next = (last_d1 & mem.rd_valid) | (run_start & (pass_left == '0));

    // read port straight off the replay state
    assign mem.rd_en   = issuing;
    assign mem.rd_addr = pc;

    // write payload, qualified by wr_en below
    always_ff @(posedge clk) begin
        mem.wr_addr <= len_cnt[im_addr_width-1:0];
        mem.wr_data <= inst_in;
    end

    //////////////////////////////////////////////////////////////////////
    // load, gap detect, replay
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            len_cnt   <= '0;
            gap_cnt   <= '0;
            pc        <= '0;
            pass_left <= '0;
            issuing   <= 1'b0;
            last_d1   <= 1'b0;
            mem.wr_en <= 1'b0;
            run_start <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            // write lands one cycle after the beat
            mem.wr_en <= beat & room;
            run_start <= load_end;
            last_d1   <= last_read;
            done      <= done_next;

            // loading
            if (beat) begin
                gap_cnt <= '0;
                if (room) begin
                    len_cnt <= len_cnt + cnt_width'(1);
                end
            end else if (~busy & (len_cnt != '0) & ~load_end) begin
                gap_cnt <= gap_cnt + cfg_width'(1);
            end

            // end of load, latch pass count
            if (load_end) begin
                busy      <= 1'b1;
                gap_cnt   <= '0;
                pc        <= '0;
                pass_left <= passes;
                issuing   <= (passes != '0);
            end

            // one read per cycle, no bubble at the pass boundary
            if (issuing) begin
                if (wrap) begin
                    pc        <= '0;
                    pass_left <= pass_left - cfg_width'(1);
                    if (pass_left == cfg_width'(1)) begin
                        issuing <= 1'b0;
                    end
                end else begin
                    pc <= pc + im_addr_width'(1);
                end
            end

            // back to loading at address 0
            if (done_next) begin
                busy    <= 1'b0;
                len_cnt <= '0;
            end
        end
    end

endmodule

//--- logic/inst_mem.sv
`timescale 1ns/1ps

module inst_mem import isa_pkg::*; (
    input logic clk,
    imem_if.mem mem
);

    //////////////////////////////////////////////////////////////////////
    // program store
    //////////////////////////////////////////////////////////////////////

    // 16 words, inferred as block RAM
    (* ram_style = "block" *)
    logic [inst_width-1:0] ram [im_depth];

    // write and read never share a cycle
    // load and replay are separate phases

    // write port
    // address and data already registered in fetch_ctrl
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
    end

    // read port
    // data registered, one cycle after rd_en
    always_ff @(posedge clk) begin
        if (mem.rd_en) begin
            mem.rd_data <= ram[mem.rd_addr];
        end
    end

    // strobe follows the data
    // settles to 0 while fetch_ctrl holds rd_en low in reset
    always_ff @(posedge clk) begin
        mem.rd_valid <= mem.rd_en;
    end

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import isa_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  run_start,
    input  logic                  rd_valid,
    input  inst_u                 rd_data,
    output logic [data_width-1:0] acc,
    output logic                  acc_valid
);

    // immediate widened to the accumulator
    logic [data_width-1:0] imm_ext;
    // shift amount from the other view of the same word
    logic [shamt_width-1:0] shamt;
    logic [data_width-1:0] acc_next;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    assign imm_ext = {{(data_width-imm_width){1'b0}}, rd_data.imm_view.imm};
    assign shamt   = rd_data.shift_view.shamt;

    // opcode sits in the same bits for both views
    always_comb begin
        case (rd_data.imm_view.opcode)
            op_ldi: acc_next = imm_ext;
            // wraps modulo 2^16
            op_add: acc_next = acc + imm_ext;
            op_sub: acc_next = acc - imm_ext;
            op_xor: acc_next = acc ^ imm_ext;
            // logical shifts, zero fill
            op_shl: acc_next = acc << shamt;
            op_shr: acc_next = acc >> shamt;
            // unknown opcode, hold
            default: acc_next = acc;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // accumulator
    //////////////////////////////////////////////////////////////////////

    // run_start is a cycle ahead of the first rd_valid
    // so the clear never collides with an update
    always_ff @(posedge clk) begin
        if (rst) begin
            acc       <= '0;
            acc_valid <= 1'b0;
        end else begin
            // one pulse per executed word
            acc_valid <= rd_valid;
            if (run_start) begin
                acc <= '0;
            end else if (rd_valid) begin
                acc <= acc_next;
            end
        end
    end

    // result shows up two cycles after the read was issued
    // one cycle in the RAM, one here

endmodule

//--- logic/stream_core.sv
`timescale 1ns/1ps

module stream_core import isa_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid,
    input  logic [inst_width-1:0] inst_in,
    input  logic                  cfg_we,
    input  logic                  cfg_addr,
    input  logic [cfg_width-1:0]  cfg_wdata,
    output logic [cfg_width-1:0]  cfg_rdata,
    output logic [data_width-1:0] acc,
    output logic                  acc_valid,
    output logic                  busy,
    output logic                  done
);

    // config to fetch
    logic [cfg_width-1:0] gap_len;
    logic [cfg_width-1:0] passes;
    // clears the accumulator at run start
    logic                 run_start;

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////

    // instruction memory port
    imem_if mem_bus ();

    cfg_regs cfg0 (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .gap_len   (gap_len),
        .passes    (passes)
    );

    fetch_ctrl fetch0 (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .inst_in   (inst_in),
        .gap_len   (gap_len),
        .passes    (passes),
        .mem       (mem_bus.ctrl),
        .run_start (run_start),
        .busy      (busy),
        .done      (done)
    );

    inst_mem mem0 (
        .clk (clk),
        .mem (mem_bus.mem)
    );

    // read data tapped off the bus
    exec_unit exec0 (
        .clk       (clk),
        .rst       (rst),
        .run_start (run_start),
        .rd_valid  (mem_bus.rd_valid),
        .rd_data   (mem_bus.rd_data),
        .acc       (acc),
        .acc_valid (acc_valid)
    );

endmodule

//--- dv/stream_core_asserts.sv
`timescale 1ns/1ps

module stream_core_asserts (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic done,
    input logic wr_en,
    input logic rd_en
);

    // failed properties so far
    int fail_cnt = 0;

    //////////////////////////////////////////////////////////////////////
    // fetch controller protocol
    //////////////////////////////////////////////////////////////////////

    // loading and replay are exclusive
    a_no_write_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !wr_en)
        else begin
            fail_cnt++;
            $error("memory write while the controller is busy");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else begin
            fail_cnt++;
            $error("done held for more than one cycle");
        end

    // one memory port direction per cycle
    a_port_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(wr_en && rd_en))
        else begin
            fail_cnt++;
            $error("read and write issued in the same cycle");
        end

    // busy drops with done and only with done
    a_busy_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> done)
        else begin
            fail_cnt++;
            $error("busy fell without a done pulse");
        end

    a_done_busy: assert property (@(posedge clk) disable iff (rst)
        done |-> $fell(busy))
        else begin
            fail_cnt++;
            $error("done pulsed without busy falling");
        end

endmodule

// attached to every fetch controller
bind fetch_ctrl stream_core_asserts asr0 (
    .clk   (clk),
    .rst   (rst),
    .busy  (busy),
    .done  (done),
    .wr_en (mem.wr_en),
    .rd_en (mem.rd_en)
);

//--- dv/tb_stream_core.sv
`timescale 1ns/1ps

module tb_stream_core import isa_pkg::*; ();

    // runs per test, and the cycle budget that follows from them
    localparam int single_runs = 6;
    localparam int multi_runs  = 4;
    localparam int num_runs    = single_runs + multi_runs + 1 + 3 + 1;
    // 20 beats with up to 15 idle each, 16 words by 15 passes, slack
    localparam int run_cycles  = 20 * 16 + 16 * 15 + 200;
    localparam int cycle_limit = num_runs * run_cycles + 500;

    logic        clk;
    logic        rst;
    logic        valid;
    logic [15:0] inst_in;
    logic        cfg_we;
    logic        cfg_addr;
    logic [3:0]  cfg_wdata;
    logic [3:0]  cfg_rdata;
    logic [15:0] acc;
    logic        acc_valid;
    logic        busy;
    logic        done;

    // model state
    logic [15:0] prog_q[$];
    logic [15:0] obs_q[$];
    int          run_passes;
    int          cur_passes;
    int          gap_cur;
    int          runs_seen;
    int          err_cnt;
    int          cycle_cnt;
    string       test_name;

    stream_core dut0 (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .inst_in   (inst_in),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .acc       (acc),
        .acc_valid (acc_valid),
        .busy      (busy),
        .done      (done)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // checking and reference model
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(string name, logic [15:0] expected, logic [15:0] actual);
        if (expected !== actual) begin
            err_cnt = err_cnt + 1;
            $display("Fail %s: expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // one word of the ISA applied to the accumulator
    function automatic logic [15:0] step_model(logic [15:0] a, logic [15:0] w);
        logic [15:0] imm;
        logic [3:0]  sh;
        logic [15:0] r;
        imm = {4'h0, w[11:0]};
        // shift form reads the nibble under the opcode
        sh  = w[11:8];
        case (w[15:12])
            op_ldi:  r = imm;
            op_add:  r = a + imm;
            op_sub:  r = a - imm;
            op_xor:  r = a ^ imm;
            op_shl:  r = a << sh;
            op_shr:  r = a >> sh;
            default: r = a;
        endcase
        return r;
    endfunction

    // whole run replayed from a zero accumulator
    task automatic score_run();
        logic [15:0] model_acc;
        int          total;
        int          k;
        model_acc = '0;
        total = prog_q.size() * run_passes;
        check_value({test_name, " result count"}, 16'(total), 16'(obs_q.size()));
        for (k = 0; k < total; k++) begin
            model_acc = step_model(model_acc, prog_q[k % prog_q.size()]);
            check_value($sformatf("%s result %0d", test_name, k), model_acc, obs_q[k]);
        end
        obs_q.delete();
    endtask

    // done arrives with the last result, so collect first
    always @(negedge clk) begin
        if (!rst) begin
            check_value("assertion failures", 16'd0, 16'(dut0.fetch0.asr0.fail_cnt));
            if (acc_valid) begin
                obs_q.push_back(acc);
            end
            if (done) begin
                // last result and done share a cycle, none at all for zero passes
                check_value({test_name, " done with last result"},
                            16'(run_passes != 0), 16'(acc_valid));
                score_run();
                runs_seen = runs_seen + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers, all entered just after a falling edge
    //////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] random_word();
        // opcodes 6 and 7 give some no-ops
        return {4'($urandom_range(7, 0)), 12'($urandom)};
    endfunction

    task automatic cfg_write(logic addr, logic [3:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    // readback is combinational, stable by the next rising edge
    task automatic cfg_read_check(logic addr, logic [3:0] expected, string name);
        cfg_addr = addr;
        @(posedge clk);
        check_value(name, 16'(expected), 16'(cfg_rdata));
        @(negedge clk);
    endtask

    // fixed_idle below 0 picks a random idle stretch up to gap_cur
    task automatic load_program(int n_beats, int fixed_idle);
        int          i;
        int          j;
        int          idle;
        logic [15:0] w;
        prog_q.delete();
        for (i = 0; i < n_beats; i++) begin
            w = random_word();
            // the memory keeps only the first 16
            if (i < im_depth) begin
                prog_q.push_back(w);
            end
            check_value({test_name, " busy in load"}, 16'd0, 16'(busy));
            valid   = 1'b1;
            inst_in = w;
            @(negedge clk);
            valid = 1'b0;
            if (i < n_beats - 1) begin
                idle = (fixed_idle >= 0) ? fixed_idle : int'($urandom_range(gap_cur, 0));
                for (j = 0; j < idle; j++) begin
                    check_value({test_name, " busy in gap"}, 16'd0, 16'(busy));
                    @(negedge clk);
                end
            end
        end
        // gap_len+1 idle cycles end the load
        for (j = 0; j <= gap_cur; j++) begin
            check_value({test_name, " busy before end"}, 16'd0, 16'(busy));
            @(negedge clk);
        end
        check_value({test_name, " run start"}, 16'd1, 16'(busy));
    endtask

    task automatic wait_run(int target);
        while (runs_seen < target) begin
            @(negedge clk);
        end
    endtask

    // busy is fixed until the next rising edge, so these beats are never taken
    task automatic drive_ignored_beats();
        while (busy) begin
            valid   = 1'(($urandom));
            inst_in = random_word();
            @(negedge clk);
        end
        valid = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          i;
        int          run_target;
        logic [3:0]  g;
        logic [3:0]  p;
        clk       = 1'b0;
        rst       = 1'b1;
        valid     = 1'b0;
        inst_in   = '0;
        cfg_we    = 1'b0;
        cfg_addr  = 1'b0;
        cfg_wdata = '0;
        runs_seen = 0;
        err_cnt   = 0;
        cycle_cnt = 0;
        void'($urandom(32'he277));
        repeat (10) @(negedge clk);
        rst = 1'b0;

        test_name = "readback";
        cfg_read_check(cfg_addr_gap, gap_reset, "readback gap reset");
        cfg_read_check(cfg_addr_passes, passes_reset, "readback passes reset");
        for (i = 0; i < 6; i++) begin
            g = 4'($urandom);
            p = 4'($urandom);
            cfg_write(cfg_addr_gap, g);
            cfg_write(cfg_addr_passes, p);
            cfg_read_check(cfg_addr_gap, g, "readback gap");
            cfg_read_check(cfg_addr_passes, p, "readback passes");
        end
        // shorter gap keeps the loads quick
        gap_cur = 4;
        cfg_write(cfg_addr_gap, 4'(gap_cur));
        cfg_write(cfg_addr_passes, 4'd1);

        test_name = "single pass";
        run_passes = 1;
        for (i = 0; i < single_runs; i++) begin
            load_program(int'($urandom_range(16, 1)), -1);
            wait_run(runs_seen + 1);
        end

        // passes written mid-run apply to the following run
        test_name = "multi pass";
        cur_passes = int'($urandom_range(5, 2));
        cfg_write(cfg_addr_passes, 4'(cur_passes));
        for (i = 0; i < multi_runs; i++) begin
            run_passes = cur_passes;
            load_program(int'($urandom_range(16, 1)), -1);
            cur_passes = int'($urandom_range(5, 2));
            cfg_write(cfg_addr_passes, 4'(cur_passes));
            wait_run(runs_seen + 1);
        end

        test_name = "over length";
        run_passes = 1;
        cfg_write(cfg_addr_passes, 4'd1);
        load_program(20, -1);
        wait_run(runs_seen + 1);

        // long program, then a short one over it
        test_name = "ignored beats";
        load_program(int'($urandom_range(16, 12)), -1);
        // the run can end on the same falling edge that stops the beats
        run_target = runs_seen + 1;
        drive_ignored_beats();
        wait_run(run_target);
        test_name = "reload";
        load_program(int'($urandom_range(8, 3)), -1);
        wait_run(runs_seen + 1);
        test_name = "zero passes";
        run_passes = 0;
        cfg_write(cfg_addr_passes, 4'd0);
        load_program(int'($urandom_range(16, 1)), -1);
        wait_run(runs_seen + 1);

        // stretches of exactly gap_len must not end the load
        test_name = "gap length";
        run_passes = 1;
        gap_cur = 2;
        cfg_write(cfg_addr_passes, 4'd1);
        cfg_write(cfg_addr_gap, 4'(gap_cur));
        load_program(10, 2);
        wait_run(runs_seen + 1);

        repeat (4) @(negedge clk);
        test_name = "end";
        check_value("run count", 16'(num_runs), 16'(runs_seen));
        check_value("results after last done", 16'd0, 16'(obs_q.size()));

        if (err_cnt == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "errors recorded");
        end
    end

endmodule

//--- project.f
logic/isa_pkg.sv
logic/imem_if.sv
logic/cfg_regs.sv
logic/fetch_ctrl.sv
logic/inst_mem.sv
logic/exec_unit.sv
logic/stream_core.sv
dv/stream_core_asserts.sv
dv/tb_stream_core.sv

//--- run.sh
#!/bin/bash
# build and run the stream_core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_stream_core

./obj_dir/Vtb_stream_core 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

if ! grep -q "TEST OK" sim.log; then
    echo "simulation ended without a pass line, see sim.log"
    exit 1
fi
